// ==== src/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// RV32I major opcodes, taken from bits 6:0 of the instruction word

// Loads use the I format
`define RV_OP_LOAD   7'b0000011

// Register-immediate arithmetic, also I format
`define RV_OP_IMM    7'b0010011

// Indirect jump, I format layout but decoded on its own
`define RV_OP_JALR   7'b1100111

// CSR and environment calls share the I format layout
`define RV_OP_SYSTEM 7'b1110011

// Direct jump with the scattered J immediate
`define RV_OP_JAL    7'b1101111

// Stores carry the immediate split around rd
`define RV_OP_STORE  7'b0100011

// Conditional branches, B format
`define RV_OP_BRANCH 7'b1100011

// Register-register arithmetic
`define RV_OP_REG    7'b0110011

// Upper immediates
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111

// Address of the first instruction after reset
`define RV_RESET_PC  32'h8000_0000

// Every RV32I instruction is four bytes wide
`define RV_INST_BYTES 32'd4

`endif

// ==== src/rv_front_pkg.sv ====
package rv_front_pkg;

  // Raw 32-bit instruction word as it arrives at fetch
  typedef logic [31:0] inst_t;

  // Byte address of an instruction
  typedef logic [31:0] addr_t;

  // Data word, used for immediates, result values and targets
  typedef logic [31:0] word_t;

  // Architectural register number, x0 to x31
  typedef logic [4:0] reg_idx_t;

  // The funct3 field of the instruction
  typedef logic [2:0] funct3_t;

  // Instruction format as seen by decode
  // Jalr gets its own entry so that resolve never looks at the opcode
  typedef enum logic [3:0] {
    fmt_none,
    fmt_r,
    fmt_i,
    fmt_jalr,
    fmt_s,
    fmt_b,
    fmt_lui,
    fmt_auipc,
    fmt_j
  } inst_fmt_t;

endpackage

// ==== src/rv_stage_if.sv ====
// Link from fetch to decode
// One word and the pc it was fetched from, under valid/ready
interface rv_fetch_if;
  logic                valid;
  logic                ready;
  rv_front_pkg::inst_t inst;
  rv_front_pkg::addr_t pc;

  // Fetch side
  modport src (output valid, output inst, output pc, input ready);

  // Decode side
  modport dst (input valid, input inst, input pc, output ready);
endinterface

// Link from decode to resolve
// Carries the split fields and the finished immediate
interface rv_decoded_if;
  logic                    valid;
  logic                    ready;
  rv_front_pkg::addr_t     pc;
  rv_front_pkg::inst_fmt_t fmt;
  rv_front_pkg::funct3_t   funct3;
  rv_front_pkg::reg_idx_t  rs1;
  rv_front_pkg::reg_idx_t  rs2;
  rv_front_pkg::reg_idx_t  rd;
  rv_front_pkg::word_t     imm;

  // Decode side drives everything but ready
  modport src (
    output valid, output pc, output fmt, output funct3,
    output rs1, output rs2, output rd, output imm,
    input ready
  );

  // Resolve side
  modport dst (
    input valid, input pc, input fmt, input funct3,
    input rs1, input rs2, input rd, input imm,
    output ready
  );
endinterface

// ==== src/rv_fetch.sv ====
`include "rv_consts.svh"

module rv_fetch (
  input  logic                clock,
  input  logic                reset,
  input  logic                inst_valid,
  output logic                inst_ready,
  input  rv_front_pkg::inst_t inst,
  rv_fetch_if.src             fetch
);

  // Running program counter, the address the next accepted word gets
  rv_front_pkg::addr_t pc_next;

  logic in_fire;
  logic out_fire;

  assign in_fire  = inst_valid && inst_ready;
  assign out_fire = fetch.valid && fetch.ready;

  // A new word fits when the entry is free or is leaving this cycle
  assign inst_ready = !fetch.valid || fetch.ready;

  // Occupancy of the single holding entry
  always_ff @(posedge clock) begin
    if (reset) begin
      fetch.valid <= 1'b0;
    end else if (in_fire) begin
      fetch.valid <= 1'b1;
    end else if (out_fire) begin
      fetch.valid <= 1'b0;
    end
  end

  // The counter only moves when a word is really taken
  always_ff @(posedge clock) begin
    if (reset) begin
      pc_next <= `RV_RESET_PC;
    end else if (in_fire) begin
      pc_next <= pc_next + `RV_INST_BYTES;
    end
  end

  // Payload of the entry, word and the pc that belongs to it
  always_ff @(posedge clock) begin
    if (in_fire) begin
      fetch.inst <= inst;
      fetch.pc   <= pc_next;
    end
  end

  // A stalled word must not change under decode
  // Inst_ready is low in that case, so nothing can overwrite the entry
  hold_stable_a : assert property (
    @(posedge clock) disable iff (reset)
    (fetch.valid && !fetch.ready) |=> ($stable(fetch.inst) && $stable(fetch.pc))
  );

endmodule

// ==== src/rv_decode.sv ====
`include "rv_consts.svh"

module rv_decode (
  input  logic      clock,
  input  logic      reset,
  rv_fetch_if.dst   fetch,
  rv_decoded_if.src decoded
);

  // Idle means the register is empty and open for a word
  // Full means a decoded word is offered to resolve
  typedef enum logic {
    idle,
    full
  } state_t;

  state_t state;

  // The held instruction and its pc
  rv_front_pkg::inst_t inst_q;
  rv_front_pkg::addr_t pc_q;

  logic [6:0] opcode;
  logic       in_fire;
  logic       out_fire;

  rv_front_pkg::inst_fmt_t fmt;

  // Ready and valid come straight from the state, so they are never high together
  assign fetch.ready   = (state == idle);
  assign decoded.valid = (state == full);

  assign in_fire  = fetch.valid && fetch.ready;
  assign out_fire = decoded.valid && decoded.ready;

  // Accept one word, then wait until resolve has taken it
  // This costs a bubble cycle between items
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle: if (in_fire) state <= full;
        full: if (out_fire) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (in_fire) begin
      inst_q <= fetch.inst;
      pc_q   <= fetch.pc;
    end
  end

  // Fixed-position fields, valid whatever the format
  assign opcode         = inst_q[6:0];
  assign decoded.rd     = inst_q[11:7];
  assign decoded.funct3 = inst_q[14:12];
  assign decoded.rs1    = inst_q[19:15];
  assign decoded.rs2    = inst_q[24:20];
  assign decoded.pc     = pc_q;
  assign decoded.fmt    = fmt;

  // Format classification from the opcode
  always_comb begin
    case (opcode)
      `RV_OP_LOAD, `RV_OP_IMM, `RV_OP_SYSTEM: fmt = rv_front_pkg::fmt_i;
      `RV_OP_JALR:   fmt = rv_front_pkg::fmt_jalr;
      `RV_OP_STORE:  fmt = rv_front_pkg::fmt_s;
      `RV_OP_BRANCH: fmt = rv_front_pkg::fmt_b;
      `RV_OP_JAL:    fmt = rv_front_pkg::fmt_j;
      `RV_OP_REG:    fmt = rv_front_pkg::fmt_r;
      `RV_OP_LUI:    fmt = rv_front_pkg::fmt_lui;
      `RV_OP_AUIPC:  fmt = rv_front_pkg::fmt_auipc;
      default:       fmt = rv_front_pkg::fmt_none;
    endcase
  end

  // Immediate builder, one arm per format
  always_comb begin
    case (fmt)
      rv_front_pkg::fmt_i, rv_front_pkg::fmt_jalr:
        decoded.imm = {{20{inst_q[31]}}, inst_q[31:20]};
      // Store offset is split around the rd slot
      rv_front_pkg::fmt_s:
        decoded.imm = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
      // Branch offsets are in halfwords, so bit 0 is always zero
      rv_front_pkg::fmt_b:
        decoded.imm = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25],
                       inst_q[11:8], 1'b0};
      rv_front_pkg::fmt_j:
        decoded.imm = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20],
                       inst_q[30:21], 1'b0};
      rv_front_pkg::fmt_lui, rv_front_pkg::fmt_auipc:
        decoded.imm = {inst_q[31:12], 12'b0};
      // R format has no immediate, funct7 is passed through instead
      rv_front_pkg::fmt_r:
        decoded.imm = {25'b0, inst_q[31:25]};
      default:
        decoded.imm = '0;
    endcase
  end

  // A word offered to resolve stays offered and unchanged until it is taken
  offer_hold_a : assert property (
    @(posedge clock) disable iff (reset)
    (decoded.valid && !decoded.ready) |=>
      (decoded.valid && $stable(decoded.imm) && $stable(decoded.pc))
  );

endmodule

// ==== src/rv_resolve.sv ====
`include "rv_consts.svh"

module rv_resolve (
  input  logic                    clock,
  input  logic                    reset,
  rv_decoded_if.dst               decoded,
  output logic                    res_valid,
  input  logic                    res_ready,
  output rv_front_pkg::addr_t     res_pc,
  output rv_front_pkg::inst_fmt_t res_fmt,
  output rv_front_pkg::reg_idx_t  res_rd,
  output rv_front_pkg::reg_idx_t  res_rs1,
  output rv_front_pkg::reg_idx_t  res_rs2,
  output rv_front_pkg::funct3_t   res_funct3,
  output rv_front_pkg::word_t     res_imm,
  output rv_front_pkg::word_t     res_value,
  output rv_front_pkg::word_t     res_target
);

  rv_front_pkg::word_t value;
  rv_front_pkg::word_t target;
  rv_front_pkg::word_t pc_plus_imm;
  rv_front_pkg::word_t pc_plus_step;

  logic in_fire;

  // Same rule as fetch, take a new item when empty or draining
  assign decoded.ready = !res_valid || res_ready;
  assign in_fire       = decoded.valid && decoded.ready;

  // Both adders are shared between value and target
  assign pc_plus_imm  = decoded.pc + decoded.imm;
  assign pc_plus_step = decoded.pc + `RV_INST_BYTES;

  // Value written to rd, link address for the jumps
  always_comb begin
    case (decoded.fmt)
      rv_front_pkg::fmt_auipc:                     value = pc_plus_imm;
      rv_front_pkg::fmt_j, rv_front_pkg::fmt_jalr: value = pc_plus_step;
      default:                                     value = decoded.imm;
    endcase
  end

  // Taken-path target for jal and branches; jalr falls back to the next pc
  // because its base register is not available here
  always_comb begin
    case (decoded.fmt)
      rv_front_pkg::fmt_j, rv_front_pkg::fmt_b: target = pc_plus_imm;
      default:                                  target = pc_plus_step;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      res_valid <= 1'b0;
    end else if (in_fire) begin
      res_valid <= 1'b1;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

  // Output entry payload
  always_ff @(posedge clock) begin
    if (in_fire) begin
      res_pc     <= decoded.pc;
      res_fmt    <= decoded.fmt;
      res_rd     <= decoded.rd;
      res_rs1    <= decoded.rs1;
      res_rs2    <= decoded.rs2;
      res_funct3 <= decoded.funct3;
      res_imm    <= decoded.imm;
      res_value  <= value;
      res_target <= target;
    end
  end

  // A result the outside has not taken yet must stay put
  value_hold_a : assert property (
    @(posedge clock) disable iff (reset)
    (res_valid && !res_ready) |=> $stable(res_value)
  );

endmodule

// ==== src/rv_front.sv ====
module rv_front (
  input  logic                    clock,
  input  logic                    reset,
  // Instruction intake
  input  logic                    inst_valid,
  output logic                    inst_ready,
  input  rv_front_pkg::inst_t     inst,
  // Result side
  output logic                    res_valid,
  input  logic                    res_ready,
  output rv_front_pkg::addr_t     res_pc,
  output rv_front_pkg::inst_fmt_t res_fmt,
  output rv_front_pkg::reg_idx_t  res_rd,
  output rv_front_pkg::reg_idx_t  res_rs1,
  output rv_front_pkg::reg_idx_t  res_rs2,
  output rv_front_pkg::funct3_t   res_funct3,
  output rv_front_pkg::word_t     res_imm,
  output rv_front_pkg::word_t     res_value,
  output rv_front_pkg::word_t     res_target
);

  // Stage-to-stage links
  rv_fetch_if   fetch_link ();
  rv_decoded_if decoded_link ();

  // Numbers the words and holds one of them
  rv_fetch u_fetch (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .inst       (inst),
    .fetch      (fetch_link)
  );

  // Splits the word and builds the immediate
  rv_decode u_decode (
    .clock   (clock),
    .reset   (reset),
    .fetch   (fetch_link),
    .decoded (decoded_link)
  );

  // Result value, next pc and the output register
  rv_resolve u_resolve (
    .clock      (clock),
    .reset      (reset),
    .decoded    (decoded_link),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res_pc     (res_pc),
    .res_fmt    (res_fmt),
    .res_rd     (res_rd),
    .res_rs1    (res_rs1),
    .res_rs2    (res_rs2),
    .res_funct3 (res_funct3),
    .res_imm    (res_imm),
    .res_value  (res_value),
    .res_target (res_target)
  );

endmodule

// ==== bench/rv_front_tb.sv ====
`include "rv_consts.svh"

module rv_front_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // Each vector line holds inst, fmt, rd, rs1, rs2, funct3, imm, value, target
  localparam int NUM_VEC = 24;
  localparam int FIELDS  = 9;

  logic                    clock;
  logic                    reset;
  logic                    inst_valid;
  logic                    inst_ready;
  rv_front_pkg::inst_t     inst;
  logic                    res_valid;
  logic                    res_ready;
  rv_front_pkg::addr_t     res_pc;
  rv_front_pkg::inst_fmt_t res_fmt;
  rv_front_pkg::reg_idx_t  res_rd;
  rv_front_pkg::reg_idx_t  res_rs1;
  rv_front_pkg::reg_idx_t  res_rs2;
  rv_front_pkg::funct3_t   res_funct3;
  rv_front_pkg::word_t     res_imm;
  rv_front_pkg::word_t     res_value;
  rv_front_pkg::word_t     res_target;

  logic [31:0] vec_mem [0:NUM_VEC*FIELDS-1];
  // Idle cycles before each word, drawn up front so the sequence is fixed
  int          gap_len [NUM_VEC];
  integer      seed;
  // Index of the next result the checker expects
  int          out_idx;

  rv_front u_rv_front (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .inst       (inst),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res_pc     (res_pc),
    .res_fmt    (res_fmt),
    .res_rd     (res_rd),
    .res_rs1    (res_rs1),
    .res_rs2    (res_rs2),
    .res_funct3 (res_funct3),
    .res_imm    (res_imm),
    .res_value  (res_value),
    .res_target (res_target)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    assert (got === expected) else begin
      $display("ERROR %0t ns: result %0d field %s is %h, expected %h",
               $time, out_idx, name, got, expected);
      stop_with_failure("result field mismatch");
    end
  endtask

  // Stimulus: reset, the post-reset state, then every word in file order
  initial begin
    seed       = 32'hefa0;
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    res_ready  = 1'b0;
    out_idx    = 0;
    $readmemh("bench/rv_front_vectors.txt", vec_mem);
    for (int i = 0; i < NUM_VEC; i++) begin
      gap_len[i] = $random(seed) & 3;
    end
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    // Fetch starts empty, so the front end must take a word at once
    assert (inst_ready === 1'b1 && res_valid === 1'b0) else begin
      stop_with_failure("after reset inst_ready is not high or res_valid is not low");
    end
    for (int idx = 0; idx < NUM_VEC; idx++) begin
      if (gap_len[idx] != 0) begin
        inst_valid <= 1'b0;
        repeat (gap_len[idx]) @(posedge clock);
      end
      inst_valid <= 1'b1;
      inst       <= vec_mem[idx * FIELDS];
      @(posedge clock);
      // Hold the word until the edge that transfers it
      while (!inst_ready) begin
        @(posedge clock);
      end
    end
    inst_valid <= 1'b0;
    wait (out_idx == NUM_VEC);
    // A few more cycles so that a duplicated result would still show up
    repeat (10) @(posedge clock);
    assert (res_valid === 1'b0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      stop_with_failure("a result is still offered after the last expected one");
    end
  end

  // Random back-pressure, high on about three cycles out of four
  always @(posedge clock) begin
    if (!reset) begin
      res_ready <= (($random(seed) & 3) != 0);
    end
  end

  // Every handshake takes the next vector, so loss or reordering shows as a mismatch
  always @(posedge clock) begin : check_results
    int base;
    if (!reset && res_valid && res_ready) begin
      assert (out_idx < NUM_VEC) else begin
        stop_with_failure("more results came out than words went in");
      end
      base = out_idx * FIELDS;
      // The pc of word n is the reset pc plus n steps
      compare_field("pc", res_pc, `RV_RESET_PC + `RV_INST_BYTES * out_idx);
      compare_field("fmt", {28'b0, res_fmt}, vec_mem[base + 1]);
      compare_field("rd", {27'b0, res_rd}, vec_mem[base + 2]);
      compare_field("rs1", {27'b0, res_rs1}, vec_mem[base + 3]);
      compare_field("rs2", {27'b0, res_rs2}, vec_mem[base + 4]);
      compare_field("funct3", {29'b0, res_funct3}, vec_mem[base + 5]);
      compare_field("imm", res_imm, vec_mem[base + 6]);
      compare_field("value", res_value, vec_mem[base + 7]);
      compare_field("target", res_target, vec_mem[base + 8]);
      out_idx = out_idx + 1;
    end
  end

  // Forty cycles per word is far above the worst case under back-pressure
  initial begin : watchdog
    repeat (NUM_VEC * 40) @(posedge clock);
    stop_with_failure("timeout: not all results arrived");
  end

endmodule

// ==== bench/rv_front_vectors.txt ====
// Columns: inst fmt rd rs1 rs2 funct3 imm value target, all hex
// Line n is fetched from pc 80000000 + 4*n; fmt 0 none 1 r 2 i 3 jalr 4 s 5 b 6 lui 7 auipc 8 j
FFF10093 2 01 02 1F 0 FFFFFFFF FFFFFFFF 80000004 // addi x1, x2, -1
12330293 2 05 06 03 0 00000123 00000123 80000008 // addi x5, x6, 0x123
FF85A503 2 0A 0B 18 2 FFFFFFF8 FFFFFFF8 8000000C // lw x10, -8(x11)
010280E7 3 01 05 10 0 00000010 80000010 80000010 // jalr x1, 16(x5)
FFC08067 3 00 01 1C 0 FFFFFFFC 80000014 80000014 // jalr x0, -4(x1)
00742623 4 0C 08 07 2 0000000C 0000000C 80000018 // sw x7, 12(x8)
FE950EA3 4 1D 0A 09 0 FFFFFFFD FFFFFFFD 8000001C // sb x9, -3(x10)
00208863 5 10 01 02 0 00000010 00000010 8000002C // beq x1, x2, +16
FE419CE3 5 19 03 04 1 FFFFFFF8 FFFFFFF8 80000018 // bne x3, x4, -8
001000EF 8 01 00 01 0 00000800 80000028 80000824 // jal x1, +2048
FF1FF06F 8 00 1F 11 7 FFFFFFF0 8000002C 80000018 // jal x0, -16
ABCDE7B7 6 0F 1B 1C 6 ABCDE000 ABCDE000 80000030 // lui x15, 0xabcde
00010197 7 03 02 00 0 00010000 80010030 80000034 // auipc x3, 0x10
FFFFF217 7 04 1F 1F 7 FFFFF000 7FFFF034 80000038 // auipc x4, 0xfffff
00838333 1 06 07 08 0 00000000 00000000 8000003C // add x6, x7, x8
40B504B3 1 09 0A 0B 0 00000020 00000020 80000040 // sub x9, x10, x11
40E6D633 1 0C 0D 0E 5 00000020 00000020 80000044 // sra x12, x13, x14
12345F8B 0 1F 08 03 5 00000000 00000000 80000048 // custom-0 opcode, not decoded
300110F3 2 01 02 00 1 00000300 00000300 8000004C // csrrw x1, mstatus, x2
800AAA13 2 14 15 00 2 FFFFF800 FFFFF800 80000050 // slti x20, x21, -2048
7E62DFE3 5 1F 05 06 5 00000FFE 00000FFE 8000104E // bge x5, x6, +4094
7FF0AFA3 4 1F 01 1F 2 000007FF 000007FF 80000058 // sw x31, 2047(x1)
7FFFF2EF 8 05 1F 1F 7 000FFFFE 8000005C 80100056 // jal x5, +1048574
00001037 6 00 00 00 1 00001000 00001000 80000060 // lui x0, 0x1

// ==== compile.f ====
+incdir+src
src/rv_front_pkg.sv
src/rv_stage_if.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_resolve.sv
src/rv_front.sv
bench/rv_front_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the rv_front testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module rv_front_tb -Mdir obj_dir -o rv_front_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rv_front_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi
